// File: verilog/jtag_dtm_pkg.sv
// shared widths and codes for the debug transport; IR is 5 bits and the DMI register is 44 bits
package jtag_dtm_pkg;

    // register widths
    localparam int IR_WIDTH       = 5;
    localparam int ABITS          = 10;
    localparam int DMI_DATA_WIDTH = 32;
    localparam int DMI_WIDTH      = ABITS + DMI_DATA_WIDTH + 2;

    typedef logic [IR_WIDTH-1:0]       ir_t;
    typedef logic [ABITS-1:0]          dmi_addr_t;
    typedef logic [DMI_DATA_WIDTH-1:0] dmi_data_t;
    typedef logic [1:0]                dmi_op_t;
    // address on top, data in the middle, op in the low two bits
    typedef logic [DMI_WIDTH-1:0]      dmi_reg_t;

    // any code not listed here behaves as bypass
    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_CUSTOM = 5'h0A;
    localparam ir_t IR_DMI    = 5'h11;
    localparam ir_t IR_BYPASS = 5'h1F;

    // ops towards the debug module
    localparam dmi_op_t OP_NOP      = 2'd0;
    localparam dmi_op_t OP_READ     = 2'd1;
    localparam dmi_op_t OP_WRITE    = 2'd2;
    localparam dmi_op_t OP_RESERVED = 2'd3;

    // status returned on a completed read
    localparam dmi_op_t OP_SUCCESS = 2'd0;

    typedef enum logic [3:0] {
        ST_TLR,
        ST_RUN_IDLE,
        ST_SELECT_DR,
        ST_CAPTURE_DR,
        ST_SHIFT_DR,
        ST_EXIT1_DR,
        ST_PAUSE_DR,
        ST_EXIT2_DR,
        ST_UPDATE_DR,
        ST_SELECT_IR,
        ST_CAPTURE_IR,
        ST_SHIFT_IR,
        ST_EXIT1_IR,
        ST_PAUSE_IR,
        ST_EXIT2_IR,
        ST_UPDATE_IR
    } tap_state_t;

endpackage

// File: verilog/jtag_pin_sync.sv
// needs SYNC_STAGES >= 1; jtag_clk must stay stable for several clk cycles per half period
`timescale 1ns/1ps

module jtag_pin_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tms_o,
    output logic tdi_o
);

    // lane 2 is tck, lane 1 tms, lane 0 tdi; one extra stage for edge detection
    logic [SYNC_STAGES:0][2:0] pin_q;
    logic tck_rise_q;
    logic tck_fall_q;
    logic tck_sync;
    logic tck_prev;

    assign tck_sync = pin_q[SYNC_STAGES-1][2];
    assign tck_prev = pin_q[SYNC_STAGES][2];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pin_q      <= '0;
            tck_rise_q <= 1'b0;
            tck_fall_q <= 1'b0;
        end
        else
        begin
            pin_q      <= {pin_q[SYNC_STAGES-1:0], {jtag_clk_i, jtag_tms_i, jtag_tdi_i}};
            tck_rise_q <= tck_sync & ~tck_prev;
            tck_fall_q <= ~tck_sync & tck_prev;
        end
    end

    assign tck_rise_o = tck_rise_q;
    assign tck_fall_o = tck_fall_q;
    // tms and tdi leave the last stage, in step with the edge pulses
    assign tms_o      = pin_q[SYNC_STAGES][1];
    assign tdi_o      = pin_q[SYNC_STAGES][0];

endmodule

// File: verilog/tap_controller.sv
// TAP state machine stepping on tck_rise pulses; all strobes are single clk pulses with tck_rise
`timescale 1ns/1ps

module tap_controller
    import jtag_dtm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_rise_i,
    input  logic       tms_i,
    output tap_state_t state_o,
    output logic       capture_dr_o,
    output logic       shift_dr_o,
    output logic       update_dr_o,
    output logic       capture_ir_o,
    output logic       shift_ir_o,
    output logic       update_ir_o,
    output logic       tlr_reset_o
);

    tap_state_t state_q;
    tap_state_t state_d;

    // standard IEEE 1149.1 graph
    always_comb
    begin
        case (state_q)
            ST_TLR:        state_d = tms_i ? ST_TLR       : ST_RUN_IDLE;
            ST_RUN_IDLE:   state_d = tms_i ? ST_SELECT_DR : ST_RUN_IDLE;
            ST_SELECT_DR:  state_d = tms_i ? ST_SELECT_IR : ST_CAPTURE_DR;
            ST_CAPTURE_DR: state_d = tms_i ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_SHIFT_DR:   state_d = tms_i ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_EXIT1_DR:   state_d = tms_i ? ST_UPDATE_DR : ST_PAUSE_DR;
            ST_PAUSE_DR:   state_d = tms_i ? ST_EXIT2_DR  : ST_PAUSE_DR;
            ST_EXIT2_DR:   state_d = tms_i ? ST_UPDATE_DR : ST_SHIFT_DR;
            ST_UPDATE_DR:  state_d = tms_i ? ST_SELECT_DR : ST_RUN_IDLE;
            ST_SELECT_IR:  state_d = tms_i ? ST_TLR       : ST_CAPTURE_IR;
            ST_CAPTURE_IR: state_d = tms_i ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_SHIFT_IR:   state_d = tms_i ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_EXIT1_IR:   state_d = tms_i ? ST_UPDATE_IR : ST_PAUSE_IR;
            ST_PAUSE_IR:   state_d = tms_i ? ST_EXIT2_IR  : ST_PAUSE_IR;
            ST_EXIT2_IR:   state_d = tms_i ? ST_UPDATE_IR : ST_SHIFT_IR;
            ST_UPDATE_IR:  state_d = tms_i ? ST_SELECT_DR : ST_RUN_IDLE;
            default:       state_d = ST_TLR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state_q <= ST_TLR;
        else if (tck_rise_i)
            state_q <= state_d;
    end

    // actions belong to the state the rising edge is taken in
    assign capture_dr_o = tck_rise_i && (state_q == ST_CAPTURE_DR);
    assign shift_dr_o   = tck_rise_i && (state_q == ST_SHIFT_DR);
    assign update_dr_o  = tck_rise_i && (state_q == ST_UPDATE_DR);
    assign capture_ir_o = tck_rise_i && (state_q == ST_CAPTURE_IR);
    assign shift_ir_o   = tck_rise_i && (state_q == ST_SHIFT_IR);
    assign update_ir_o  = tck_rise_i && (state_q == ST_UPDATE_IR);
    assign tlr_reset_o  = tck_rise_i && (state_q == ST_TLR);

    assign state_o = state_q;

endmodule

// File: verilog/tap_instruction_reg.sv
// 5-bit instruction register, LSB shifted first; IDCODE after reset or Test-Logic-Reset
`timescale 1ns/1ps

module tap_instruction_reg
    import jtag_dtm_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic capture_ir_i,
    input  logic shift_ir_i,
    input  logic update_ir_i,
    input  logic tlr_reset_i,
    input  logic tdi_i,
    output ir_t  ir_o,
    output logic ir_tdo_bit_o
);

    ir_t ir_shift_q;
    ir_t ir_q;

    // capture pattern ends in 01 as 1149.1 asks
    always_ff @(posedge clk)
    begin
        if (capture_ir_i)
            ir_shift_q <= ir_t'(1);
        else if (shift_ir_i)
            ir_shift_q <= {tdi_i, ir_shift_q[IR_WIDTH-1:1]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || tlr_reset_i)
            ir_q <= IR_IDCODE;
        else if (update_ir_i)
            ir_q <= ir_shift_q;
    end

    assign ir_o         = ir_q;
    assign ir_tdo_bit_o = ir_shift_q[0];

endmodule

// File: verilog/tap_data_regs.sv
// IDCODE is read-only; codes other than IDCODE, custom and DMI select the 1-bit bypass
`timescale 1ns/1ps

module tap_data_regs
    import jtag_dtm_pkg::*;
#(
    parameter logic [31:0] JTAG_ID      = 32'h12345678,
    parameter logic [31:0] CUSTOM_RESET = 32'h0A0B0C0D
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ir_t        ir_i,
    input  tap_state_t state_i,
    input  logic       capture_dr_i,
    input  logic       shift_dr_i,
    input  logic       update_dr_i,
    input  logic       tck_fall_i,
    input  logic       tdi_i,
    input  logic       ir_tdo_bit_i,
    input  dmi_reg_t   dmi_capture_value_i,
    output logic       dmi_update_o,
    output dmi_reg_t   dmi_update_value_o,
    output logic       jtag_tdo_o
);

    ir_t         ir_eff;
    logic [31:0] dr_shift_q;
    logic [31:0] custom_q;
    logic        bypass_q;
    dmi_reg_t    dmi_shift_q;
    logic        dr_tdo_bit;
    logic        tdo_q;

    // fold unknown codes onto bypass
    always_comb
    begin
        case (ir_i)
            IR_IDCODE, IR_CUSTOM, IR_DMI: ir_eff = ir_i;
            default:                      ir_eff = IR_BYPASS;
        endcase
    end

    // capture and shift with the LSB leaving first
    always_ff @(posedge clk)
    begin
        case (ir_eff)
            IR_IDCODE, IR_CUSTOM:
            begin
                if (capture_dr_i)
                    dr_shift_q <= (ir_eff == IR_IDCODE) ? JTAG_ID : custom_q;
                else if (shift_dr_i)
                    dr_shift_q <= {tdi_i, dr_shift_q[31:1]};
            end
            IR_DMI:
            begin
                if (capture_dr_i)
                    dmi_shift_q <= dmi_capture_value_i;
                else if (shift_dr_i)
                    dmi_shift_q <= {tdi_i, dmi_shift_q[DMI_WIDTH-1:1]};
            end
            default:
            begin
                if (capture_dr_i)
                    bypass_q <= 1'b0;
                else if (shift_dr_i)
                    bypass_q <= tdi_i;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            custom_q <= CUSTOM_RESET;
        else if (update_dr_i && ir_eff == IR_CUSTOM)
            custom_q <= dr_shift_q;
    end

    assign dmi_update_o       = update_dr_i && (ir_eff == IR_DMI);
    assign dmi_update_value_o = dmi_shift_q;

    always_comb
    begin
        case (ir_eff)
            IR_IDCODE, IR_CUSTOM: dr_tdo_bit = dr_shift_q[0];
            IR_DMI:               dr_tdo_bit = dmi_shift_q[0];
            default:              dr_tdo_bit = bypass_q;
        endcase
    end

    // tdo moves on the falling tck edge and holds outside the shift states
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            tdo_q <= 1'b0;
        else if (tck_fall_i && state_i == ST_SHIFT_IR)
            tdo_q <= ir_tdo_bit_i;
        else if (tck_fall_i && state_i == ST_SHIFT_DR)
            tdo_q <= dr_tdo_bit;
    end

    assign jtag_tdo_o = tdo_q;

endmodule

// File: verilog/dmi_request.sv
// no back-pressure: a new request before ack overwrites addr_o and wdata_o
`timescale 1ns/1ps

module dmi_request
    import jtag_dtm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dmi_update_i,
    input  dmi_reg_t  dmi_update_value_i,
    input  logic      ack_i,
    input  dmi_data_t rdata_i,
    output dmi_reg_t  dmi_capture_value_o,
    output dmi_addr_t addr_o,
    output dmi_data_t wdata_o,
    output logic      start_read_o,
    output logic      start_write_o
);

    dmi_reg_t  dmi_q;
    dmi_addr_t addr_q;
    dmi_data_t wdata_q;
    logic      start_read_q;
    logic      start_write_q;
    logic      read_pending_q;
    dmi_addr_t upd_addr;
    dmi_data_t upd_data;
    dmi_op_t   upd_op;

    assign upd_addr = dmi_update_value_i[DMI_WIDTH-1 -: ABITS];
    assign upd_data = dmi_update_value_i[2 +: DMI_DATA_WIDTH];
    assign upd_op   = dmi_update_value_i[1:0];

    always_ff @(posedge clk)
    begin
        if (dmi_update_i)
        begin
            addr_q  <= upd_addr;
            wdata_q <= upd_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dmi_q          <= '0;
            read_pending_q <= 1'b0;
            start_read_q   <= 1'b0;
            start_write_q  <= 1'b0;
        end
        else
        begin
            start_read_q  <= 1'b0;
            start_write_q <= 1'b0;
            // read data lands in the data field and the address stays
            if (ack_i)
            begin
                read_pending_q <= 1'b0;
                if (read_pending_q)
                    dmi_q <= {dmi_q[DMI_WIDTH-1 -: ABITS], rdata_i, OP_SUCCESS};
            end
            // a fresh update wins over a same-cycle ack
            if (dmi_update_i)
            begin
                dmi_q <= dmi_update_value_i;
                case (upd_op)
                    OP_READ:
                    begin
                        start_read_q   <= 1'b1;
                        read_pending_q <= 1'b1;
                    end
                    OP_WRITE:
                        start_write_q <= 1'b1;
                    // NOP and reserved ops raise no strobe
                    default: ;
                endcase
            end
        end
    end

    assign dmi_capture_value_o = dmi_q;
    assign addr_o              = addr_q;
    assign wdata_o             = wdata_q;
    assign start_read_o        = start_read_q;
    assign start_write_o       = start_write_q;

endmodule

// File: verilog/jtag_dtm.sv
// JTAG pins are sampled on clk, so tck must run well below clk/(2*(SYNC_STAGES+2))
`timescale 1ns/1ps

module jtag_dtm
    import jtag_dtm_pkg::*;
#(
    parameter logic [31:0] JTAG_ID      = 32'h12345678,
    parameter logic [31:0] CUSTOM_RESET = 32'h0A0B0C0D,
    parameter int          SYNC_STAGES  = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      jtag_clk_i,
    input  logic      jtag_tms_i,
    input  logic      jtag_tdi_i,
    input  logic      ack_i,
    input  dmi_data_t rdata_i,
    output logic      jtag_tdo_o,
    output dmi_addr_t addr_o,
    output dmi_data_t wdata_o,
    output logic      start_read_o,
    output logic      start_write_o
);

    logic       tck_rise;
    logic       tck_fall;
    logic       tms_s;
    logic       tdi_s;
    tap_state_t state;
    logic       capture_dr;
    logic       shift_dr;
    logic       update_dr;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;
    logic       tlr_reset;
    ir_t        ir;
    logic       ir_tdo_bit;
    logic       dmi_update;
    dmi_reg_t   dmi_update_value;
    dmi_reg_t   dmi_capture_value;

    jtag_pin_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_pin_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .jtag_clk_i (jtag_clk_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .tck_rise_o (tck_rise),
        .tck_fall_o (tck_fall),
        .tms_o      (tms_s),
        .tdi_o      (tdi_s)
    );

    tap_controller u_tap_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_rise_i   (tck_rise),
        .tms_i        (tms_s),
        .state_o      (state),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        .tlr_reset_o  (tlr_reset)
    );

    tap_instruction_reg u_ir (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_ir_i (capture_ir),
        .shift_ir_i   (shift_ir),
        .update_ir_i  (update_ir),
        .tlr_reset_i  (tlr_reset),
        .tdi_i        (tdi_s),
        .ir_o         (ir),
        .ir_tdo_bit_o (ir_tdo_bit)
    );

    tap_data_regs #(
        .JTAG_ID      (JTAG_ID),
        .CUSTOM_RESET (CUSTOM_RESET)
    ) u_data_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .ir_i                (ir),
        .state_i             (state),
        .capture_dr_i        (capture_dr),
        .shift_dr_i          (shift_dr),
        .update_dr_i         (update_dr),
        .tck_fall_i          (tck_fall),
        .tdi_i               (tdi_s),
        .ir_tdo_bit_i        (ir_tdo_bit),
        .dmi_capture_value_i (dmi_capture_value),
        .dmi_update_o        (dmi_update),
        .dmi_update_value_o  (dmi_update_value),
        .jtag_tdo_o          (jtag_tdo_o)
    );

    dmi_request u_dmi_req (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dmi_update_i        (dmi_update),
        .dmi_update_value_i  (dmi_update_value),
        .ack_i               (ack_i),
        .rdata_i             (rdata_i),
        .dmi_capture_value_o (dmi_capture_value),
        .addr_o              (addr_o),
        .wdata_o             (wdata_o),
        .start_read_o        (start_read_o),
        .start_write_o       (start_write_o)
    );

endmodule

// File: tb/tb_jtag_dtm.sv
// replays tb/jtag_dtm_stimulus.txt from the project root; tck half period is 8 clk cycles
`timescale 1ns/1ps

module tb_jtag_dtm
    import jtag_dtm_pkg::*;
();

    localparam int    CLK_PERIOD   = 4;
    localparam int    HALF_TCK     = 8;
    localparam int    RESET_CYCLES = 3;
    localparam int    MAX_SCAN     = 64;
    localparam string STIM_FILE    = "tb/jtag_dtm_stimulus.txt";

    logic      clk;
    logic      rst_n;
    logic      jtag_clk;
    logic      jtag_tms;
    logic      jtag_tdi;
    logic      ack;
    dmi_data_t rdata;
    logic      jtag_tdo;
    dmi_addr_t addr;
    dmi_data_t wdata;
    logic      start_read;
    logic      start_write;

    // one entry per stimulus line
    string       kind_q[$];
    string       strobe_q[$];
    string       name_q[$];
    int          len_q[$];
    logic [63:0] tdi_q[$];
    logic [63:0] tdo_q[$];
    logic [63:0] addr_q[$];
    logic [63:0] data_q[$];

    int        step_count;
    int        error_count;
    int        check_count;
    int        read_pulses;
    int        write_pulses;
    dmi_addr_t seen_addr;
    dmi_data_t seen_data;
    logic      steps_loaded;

    jtag_dtm #(
        .JTAG_ID      (32'h12345678),
        .CUSTOM_RESET (32'h0A0B0C0D),
        .SYNC_STAGES  (2)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .jtag_clk_i    (jtag_clk),
        .jtag_tms_i    (jtag_tms),
        .jtag_tdi_i    (jtag_tdi),
        .ack_i         (ack),
        .rdata_i       (rdata),
        .jtag_tdo_o    (jtag_tdo),
        .addr_o        (addr),
        .wdata_o       (wdata),
        .start_read_o  (start_read),
        .start_write_o (start_write)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // drop the null bytes that $sscanf leaves in front of short words
    function automatic string text_of(input logic [8*32-1:0] raw);
        string s;
        int    i;
        s = "";
        for (i = 31; i >= 0; i--)
            if (raw[8*i +: 8] != 8'h00)
                s = $sformatf("%s%c", s, raw[8*i +: 8]);
        return s;
    endfunction

    task automatic load_stimulus();
        int               fd;
        int               fields;
        int               len_f;
        logic [8*200-1:0] line_buf;
        logic [8*32-1:0]  kind_f;
        logic [8*32-1:0]  strobe_f;
        logic [8*32-1:0]  name_f;
        logic [63:0]      tdi_f;
        logic [63:0]      tdo_f;
        logic [63:0]      addr_f;
        logic [63:0]      data_f;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            error_count++;
        end
        else
        begin
            line_buf = '0;
            while ($fgets(line_buf, fd) != 0)
            begin
                fields = $sscanf(line_buf, "%s %d %h %h %h %h %s %s", kind_f, len_f,
                                 tdi_f, tdo_f, addr_f, data_f, strobe_f, name_f);
                // comment lines stop after the first word
                if (fields == 8)
                begin
                    kind_q.push_back(text_of(kind_f));
                    strobe_q.push_back(text_of(strobe_f));
                    name_q.push_back(text_of(name_f));
                    len_q.push_back(len_f);
                    tdi_q.push_back(tdi_f);
                    tdo_q.push_back(tdo_f);
                    addr_q.push_back(addr_f);
                    data_q.push_back(data_f);
                end
                line_buf = '0;
            end
            $fclose(fd);
            if (kind_q.size() == 0)
            begin
                $display("the stimulus file holds no usable steps");
                error_count++;
            end
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    // waits one falling clk edge and counts the bus strobes seen there
    task automatic sample_strobes();
        @(negedge clk);
        if (start_read)
        begin
            read_pulses++;
            seen_addr = addr;
            seen_data = wdata;
        end
        if (start_write)
        begin
            write_pulses++;
            seen_addr = addr;
            seen_data = wdata;
        end
    endtask

    // one tck period with new TMS/TDI in the low half and TDO sampled before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        jtag_clk = 1'b0;
        jtag_tms = tms;
        jtag_tdi = tdi;
        repeat (HALF_TCK) @(negedge clk);
        tdo = jtag_tdo;
        jtag_clk = 1'b1;
        // bus strobes of this rising edge land inside the high half
        repeat (HALF_TCK) sample_strobes();
    endtask

    // starts and ends in Run-Test/Idle
    task automatic shift_scan(input logic is_ir, input int len, input logic [63:0] tdi_bits,
                              output logic [63:0] tdo_bits);
        logic tdo_bit;
        int   i;
        tdo_bits = '0;
        tck_cycle(1'b1, 1'b0, tdo_bit);
        if (is_ir)
            tck_cycle(1'b1, 1'b0, tdo_bit);
        // to Capture, then the capture edge into Shift
        tck_cycle(1'b0, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, tdo_bit);
        for (i = 0; i < len; i++)
        begin
            tck_cycle(i == len - 1, tdi_bits[i], tdo_bit);
            tdo_bits[i] = tdo_bit;
        end
        // Exit1 to Update, then the update edge
        tck_cycle(1'b1, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic reset_tap_logic();
        logic tdo_bit;
        int   i;
        for (i = 0; i < 5; i++)
            tck_cycle(1'b1, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic pulse_ack(input dmi_data_t data);
        rdata = data;
        // some bus latency before the response
        repeat (3) sample_strobes();
        ack = 1'b1;
        sample_strobes();
        ack = 1'b0;
        // an ack must not start a new bus request
        repeat (HALF_TCK) sample_strobes();
    endtask

    task automatic run_step(input int k);
        logic [63:0] scan_out;
        logic [63:0] mask;
        read_pulses  = 0;
        write_pulses = 0;
        if (kind_q[k] == "ir" || kind_q[k] == "dr")
        begin
            shift_scan(kind_q[k] == "ir", len_q[k], tdi_q[k], scan_out);
            mask = (len_q[k] >= 64) ? '1 : ((64'd1 << len_q[k]) - 64'd1);
            check_value(name_q[k], "tdo", tdo_q[k] & mask, scan_out & mask);
        end
        else if (kind_q[k] == "ack")
            pulse_ack(tdi_q[k][31:0]);
        else if (kind_q[k] == "tlr")
            reset_tap_logic();
        else
        begin
            $display("step %s has an unknown kind %s", name_q[k], kind_q[k]);
            error_count++;
        end
        if (strobe_q[k] != "none" && strobe_q[k] != "rd" && strobe_q[k] != "wr")
        begin
            $display("step %s has an unknown strobe %s", name_q[k], strobe_q[k]);
            error_count++;
        end
        check_value(name_q[k], "start_read_o pulses", 64'(strobe_q[k] == "rd"),
                    64'(read_pulses));
        check_value(name_q[k], "start_write_o pulses", 64'(strobe_q[k] == "wr"),
                    64'(write_pulses));
        if (strobe_q[k] == "rd" || strobe_q[k] == "wr")
        begin
            check_value(name_q[k], "addr_o", addr_q[k], 64'(seen_addr));
            check_value(name_q[k], "wdata_o", data_q[k], 64'(seen_data));
        end
    endtask

    // one stimulus line never needs more than MAX_SCAN tck periods
    initial
    begin
        int limit_ns;
        wait (steps_loaded == 1'b1);
        limit_ns = step_count * MAX_SCAN * 2 * HALF_TCK * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the stimulus did not complete within %0d ns", limit_ns);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        int   k;
        logic tdo_bit;
        rst_n        = 1'b0;
        jtag_clk     = 1'b0;
        jtag_tms     = 1'b1;
        jtag_tdi     = 1'b0;
        ack          = 1'b0;
        rdata        = '0;
        error_count  = 0;
        check_count  = 0;
        read_pulses  = 0;
        write_pulses = 0;
        seen_addr    = '0;
        seen_data    = '0;
        steps_loaded = 1'b0;
        load_stimulus();
        step_count   = kind_q.size();
        steps_loaded = (error_count == 0);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (error_count == 0)
        begin
            // leave Test-Logic-Reset for Run-Test/Idle
            tck_cycle(1'b0, 1'b0, tdo_bit);
            for (k = 0; k < step_count; k++)
                run_step(k);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: tb/jtag_dtm_stimulus.txt
# kind len tdi tdo addr data strobe name   (values in hex, scan bits go LSB first)
# kinds ir dr ack tlr; for ack the tdi column is rdata; strobe is none, rd or wr
dr  32 00000000   12345678   000 00000000 none idcode_after_reset
ir  5  1f         01         000 00000000 none ir_select_bypass
dr  8  a5         4a         000 00000000 none bypass_delay
ir  5  05         01         000 00000000 none ir_select_unknown
dr  8  3c         78         000 00000000 none unknown_code_bypass
ir  5  0a         01         000 00000000 none ir_select_custom
dr  32 deadbeef   0a0b0c0d   000 00000000 none custom_reset_value
dr  32 00000000   deadbeef   000 00000000 none custom_readback
ir  5  11         01         000 00000000 none ir_select_dmi
dr  44 404488cd12 0          010 11223344 wr   dmi_write
dr  44 8000000001 404488cd12 020 00000000 rd   dmi_read
ack 0  5a5aa5a5   0          000 00000000 none read_ack
dr  44 0          81696a9694 000 00000000 none dmi_nop_readback
tlr 0  0          0          000 00000000 none tap_reset
dr  32 00000000   12345678   000 00000000 none idcode_after_tlr

// File: jtag_dtm.f
verilog/jtag_dtm_pkg.sv
verilog/jtag_pin_sync.sv
verilog/tap_controller.sv
verilog/tap_instruction_reg.sv
verilog/tap_data_regs.sv
verilog/dmi_request.sv
verilog/jtag_dtm.sv
tb/tb_jtag_dtm.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the jtag_dtm testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f jtag_dtm.f --top-module tb_jtag_dtm \
    -Mdir obj_dir -o sim_jtag_dtm

./obj_dir/sim_jtag_dtm | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "simulation reported errors, see $LOG"
    exit 1
fi
echo "simulation log in $LOG"
